//--- tb.f
source/meas_cfg_pkg.sv
source/meas_sample_pkg.sv
source/meas_apb_regs.sv
source/modulation_seq.sv
source/adc_capture.sv
source/az_combiner.sv
source/meas_top.sv
tb/meas_properties.sv
tb/tb_meas_top.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
verilator --binary --timing --assert --top-module tb_meas_top -f tb.f -o sim_meas \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_meas > sim.log 2>&1
cat sim.log
grep -q "^Finished with no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb/tb_meas_top.sv
// ADC is modelled here with 3 to 20 cycle latency, data and delays come from a seeded LFSR
`timescale 1ns/1ns
`default_nettype none

module tb_meas_top;

  import meas_cfg_pkg::*;

  localparam int ADC_WIDTH   = 24;
  localparam int PRE_N       = 40;
  localparam int SET_N       = 25;
  localparam int STALL_N     = 200;
  localparam int IDLE_WATCH  = 300;
  localparam int NUM_READ    = 28;
  localparam int MAX_CYCLE   = PRE_N + SET_N + 2 * STALL_N + 30;
  localparam int CYCLE_LIMIT = (NUM_READ * MAX_CYCLE + IDLE_WATCH + 1000) * 2;

  logic clk;
  logic reset;
  logic psel;
  logic penable;
  logic pwrite;
  logic [4:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic adc_valid;
  logic signed [ADC_WIDTH-1:0] adc_data;
  logic adc_trig;
  logic [3:0] azmux;
  logic sw_pc_ctl;
  logic led;
  logic [1:0] monitor;

  logic [31:0] lfsr = 32'h3711_5ec1;
  int cyc = 0;
  int error_count = 0;
  int test_num = 0;
  int test_start_errors = 0;
  int trig_count = 0;
  int stall_next = 0;
  logic [31:0] expected_count = 0;
  logic signed [ADC_WIDTH-1:0] conv_data[$];
  logic [3:0] conv_mux[$];

  meas_top #(
    .ADC_WIDTH   (ADC_WIDTH),
    .COUNT_WIDTH (24)
  ) u_meas_top (
    .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .adc_valid, .adc_data, .adc_trig, .azmux, .sw_pc_ctl, .led, .monitor
  );

  bind meas_top meas_properties u_props (
    .clk, .reset, .adc_trig, .adc_valid, .azmux, .sw_pc_ctl, .az_mode (u_seq.az_q)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog
  initial
  begin
    forever
    begin
      @(posedge clk);
      cyc++;
      if (cyc > CYCLE_LIMIT)
      begin
        $display("timeout: simulation exceeded %0d cycles", CYCLE_LIMIT);
        $display("Finished with errors");
        $finish;
      end
    end
  end

  // counts every trigger, also while the ADC model is busy with a conversion
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (adc_trig)
        trig_count++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Fibonacci LFSR with taps 32 22 2 1

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  ////////////////////////////////////////////////////////////
  // ADC model

  initial
  begin
    logic [31:0] bits;
    int delay;
    logic signed [ADC_WIDTH-1:0] value;
    adc_valid = 1'b0;
    adc_data  = '0;
    forever
    begin
      @(negedge clk);
      if (adc_trig)
      begin
        take_bits(5, bits);
        delay = 3 + int'(bits % 18);
        if (stall_next != 0)
        begin
          delay = stall_next;
          stall_next = 0;
        end
        take_bits(ADC_WIDTH, bits);
        value = bits[ADC_WIDTH-1:0];
        conv_data.push_back(value);
        conv_mux.push_back(azmux);
        repeat (delay) @(posedge clk);
        #1;
        adc_valid = 1'b1;
        adc_data  = value;
        @(posedge clk);
        #1;
        adc_valid = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // APB master

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data, output logic err);
    @(posedge clk);
    #1;
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    err = pslverr;
    check_value("pready", 32'(pready), 1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    #1;
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    check_value("pready", 32'(pready), 1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // expected reading and checks

  function automatic int expected_reading(input logic az, input logic signed [ADC_WIDTH-1:0] hi,
                                          input logic signed [ADC_WIDTH-1:0] lo);
    int h;
    int l;
    h = hi;
    l = lo;
    return az ? h - l : h;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error %0t: %s got %h expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  // waits for the next count step and checks the reading it marks
  task automatic check_reading(input logic az);
    logic [31:0] cnt;
    logic [31:0] rd;
    logic err;
    logic signed [ADC_WIDTH-1:0] hi;
    logic signed [ADC_WIDTH-1:0] lo;
    apb_read(REG_COUNT, cnt, err);
    while (cnt == expected_count)
      apb_read(REG_COUNT, cnt, err);
    expected_count++;
    check_value("reading count", cnt, expected_count);
    apb_read(REG_READING, rd, err);
    lo = '0;
    if (conv_data.size() < (az ? 2 : 1))
    begin
      $display("reading arrived without a recorded conversion");
      error_count++;
    end
    else
    begin
      hi = conv_data.pop_front();
      check_value("HI conversion mux", 32'(conv_mux.pop_front()), 32'(AZMUX_HI));
      if (az)
      begin
        lo = conv_data.pop_front();
        check_value("LO conversion mux", 32'(conv_mux.pop_front()), 32'(AZMUX_LO));
      end
      check_value("reading", rd, 32'(expected_reading(az, hi, lo)));
    end
  endtask

  // clear run, take the in-flight reading and wait for the sequencer to go idle
  task automatic stop_run(input logic az);
    logic err;
    apb_write(REG_CTRL, {30'b0, az, 1'b0}, err);
    check_reading(az);
    @(negedge clk);
    while (monitor != 2'b00)
      @(negedge clk);
    repeat (4) @(posedge clk);
    // led toggles once per completed cycle and each cycle gives one reading
    check_value("led", 32'(led), 32'(expected_count[0]));
  endtask

  task automatic finish_test(input string name);
    test_num++;
    $display("test %0d %s: %s", test_num, name,
             (error_count == test_start_errors) ? "ok" : "FAILED");
    test_start_errors = error_count;
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus

  initial
  begin
    logic [31:0] data;
    logic [31:0] cnt0;
    logic [31:0] rd0;
    logic err;
    int t0;
    int trig0;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // reset state and register access
    check_value("adc_trig", 32'(adc_trig), 0);
    check_value("led", 32'(led), 0);
    check_value("monitor", 32'(monitor), 0);
    check_value("azmux", 32'(azmux), 32'(AZMUX_HI));
    check_value("sw_pc_ctl", 32'(sw_pc_ctl), 32'(SW_PC_BOOT));
    for (int a = 0; a <= 16; a += 4)
    begin
      apb_read(5'(a), data, err);
      check_value("register after reset", data, 0);
    end
    apb_write(REG_PRECHARGE, 32'h0012_3456, err);
    apb_read(REG_PRECHARGE, data, err);
    check_value("precharge readback", data, 32'h0012_3456);
    apb_write(REG_SETTLE, 32'h00ab_cdef, err);
    apb_read(REG_SETTLE, data, err);
    check_value("settle readback", data, 32'h00ab_cdef);
    apb_write(REG_CTRL, 32'h2, err);
    apb_read(REG_CTRL, data, err);
    check_value("ctrl readback", data, 32'h2);
    apb_write(REG_READING, 32'hdead_beef, err);
    apb_read(REG_READING, data, err);
    check_value("reading after write", data, 0);
    check_value("pslverr on mapped address", 32'(err), 0);
    apb_read(5'd20, data, err);
    check_value("pslverr on unmapped address", 32'(err), 1);
    apb_write(REG_CTRL, 32'h0, err);
    finish_test("reset and registers");

    // no-autozero timing and readings
    apb_write(REG_PRECHARGE, PRE_N, err);
    apb_write(REG_SETTLE, SET_N, err);
    apb_write(REG_CTRL, 32'h1, err);
    @(negedge clk);
    while (monitor != 2'b01)
      @(negedge clk);
    t0 = cyc;
    while (!adc_trig)
      @(negedge clk);
    check_value("cycles from precharge to trigger", cyc - t0, PRE_N + 2);
    for (int i = 0; i < 8; i++)
      check_reading(1'b0);
    stop_run(1'b0);
    finish_test("no-autozero readings");

    // autozero readings
    apb_write(REG_CTRL, 32'h3, err);
    for (int i = 0; i < 8; i++)
      check_reading(1'b1);
    stop_run(1'b1);
    finish_test("autozero readings");

    // ADC stall
    stall_next = STALL_N;
    trig0 = trig_count;
    apb_write(REG_CTRL, 32'h1, err);
    while (trig_count == trig0)
      @(negedge clk);
    trig0 = trig_count;
    apb_read(REG_COUNT, cnt0, err);
    apb_read(REG_READING, rd0, err);
    // each pass takes six clocks so the loop ends well before the stalled valid
    for (int i = 0; i < STALL_N / 8; i++)
    begin
      apb_read(REG_COUNT, data, err);
      check_value("count during stall", data, cnt0);
      apb_read(REG_READING, data, err);
      check_value("reading during stall", data, rd0);
    end
    check_value("triggers during stall", trig_count, trig0);
    check_reading(1'b0);
    stop_run(1'b0);
    finish_test("ADC stall");

    // stop and mode change
    apb_write(REG_CTRL, 32'h3, err);
    check_reading(1'b1);
    check_reading(1'b1);
    stop_run(1'b1);
    trig0 = trig_count;
    repeat (IDLE_WATCH) @(posedge clk);
    apb_read(REG_COUNT, data, err);
    check_value("count while stopped", data, expected_count);
    check_value("triggers while stopped", trig_count, trig0);
    apb_write(REG_CTRL, 32'h1, err);
    for (int i = 0; i < 4; i++)
      check_reading(1'b0);
    stop_run(1'b0);
    finish_test("stop and mode change");

    $display("tests %0d, readings %0d, errors %0d", test_num, expected_count, error_count);
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/meas_properties.sv
// bound into meas_top, az_mode is the sequencer's latched mode so azmux may rest at LO when idle
`timescale 1ns/1ns
`default_nettype none

module meas_properties (
  input wire       clk,
  input wire       reset,
  input wire       adc_trig,
  input wire       adc_valid,
  input wire [3:0] azmux,
  input wire       sw_pc_ctl,
  input wire       az_mode
);

  import meas_cfg_pkg::*;

  logic pending;  // a conversion was triggered and has not returned yet

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pending <= 1'b0;
    else if (adc_trig)
      pending <= 1'b1;
    else if (adc_valid)
      pending <= 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // ADC handshake

  trig_single: assert property (@(posedge clk) disable iff (reset) adc_trig |=> !adc_trig)
    else $error("adc_trig held longer than one clock");

  trig_not_pending: assert property (@(posedge clk) disable iff (reset) adc_trig |-> !pending)
    else $error("trigger issued while a conversion was pending");

  ////////////////////////////////////////////////////////////
  // analog switches

  lo_only_autozero: assert property (@(posedge clk) disable iff (reset)
    azmux == AZMUX_LO |-> az_mode)
    else $error("azmux at LO outside autozero mode");

  // charge injection from the mux must not reach the signal
  mux_change_in_boot: assert property (@(posedge clk) disable iff (reset)
    azmux != $past(azmux) |-> sw_pc_ctl == SW_PC_BOOT && $past(sw_pc_ctl) == SW_PC_BOOT)
    else $error("azmux changed while precharge switch was not in boot");

endmodule

`default_nettype wire

//--- source/meas_top.sv
// ADC_WIDTH from 16 to 24 and COUNT_WIDTH up to 24, ADC must answer each trigger with one valid
`timescale 1ns/1ns
`default_nettype none

module meas_top #(
  parameter int ADC_WIDTH   = 24,
  parameter int COUNT_WIDTH = 24
) (
  input  wire                            clk,
  input  wire                            reset,
  // APB slave
  input  wire                            psel,
  input  wire                            penable,
  input  wire                            pwrite,
  input  wire  [4:0]                     paddr,
  input  wire  [31:0]                    pwdata,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr,
  // external ADC
  input  wire                            adc_valid,
  input  wire logic signed [ADC_WIDTH-1:0] adc_data,
  output logic                           adc_trig,
  // analog switches and indicators
  output logic [3:0]                     azmux,
  output logic                           sw_pc_ctl,
  output logic                           led,
  output logic [1:0]                     monitor
);

  import meas_cfg_pkg::*;
  import meas_sample_pkg::*;

  meas_cfg_t                 cfg;
  phase_t                    trig_phase;
  sample_t                   sample;
  logic                      sample_valid;
  logic signed [ADC_WIDTH:0] reading;
  logic [31:0]               reading_count;

  ////////////////////////////////////////////////////////////
  // register block

  meas_apb_regs #(
    .ADC_WIDTH   (ADC_WIDTH),
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_regs (
    .clk, .reset,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .cfg,
    .reading, .reading_count
  );

  ////////////////////////////////////////////////////////////
  // sequencer and capture run side by side

  modulation_seq #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_seq (
    .clk, .reset, .cfg, .adc_valid,
    .adc_trig, .trig_phase, .azmux, .sw_pc_ctl, .led, .monitor
  );

  adc_capture #(
    .ADC_WIDTH (ADC_WIDTH)
  ) u_capture (
    .clk, .reset, .adc_trig, .trig_phase,
    .adc_valid, .adc_data, .sample, .sample_valid
  );

  // pairs tagged samples into readings
  az_combiner #(
    .ADC_WIDTH (ADC_WIDTH)
  ) u_combiner (
    .clk, .reset, .cfg, .sample, .sample_valid,
    .reading, .reading_count
  );

endmodule

`default_nettype wire

//--- source/az_combiner.sv
// az_mode must stay fixed between the HI and LO samples of a cycle
`timescale 1ns/1ns
`default_nettype none

module az_combiner #(
  parameter int ADC_WIDTH = 24
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire meas_cfg_pkg::meas_cfg_t cfg,
  input  wire meas_sample_pkg::sample_t sample,
  input  wire                          sample_valid,
  output logic signed [ADC_WIDTH:0]    reading,
  output logic [31:0]                  reading_count
);

  import meas_sample_pkg::*;

  logic signed [ADC_WIDTH-1:0] hi_q;       // last HI conversion
  logic signed [ADC_WIDTH-1:0] value;      // incoming sample at ADC width
  logic signed [ADC_WIDTH:0]   hi_ext;
  logic signed [ADC_WIDTH:0]   value_ext;

  // one extra bit so HI minus LO cannot overflow
  assign value     = sample.value[ADC_WIDTH-1:0];
  assign hi_ext    = {hi_q[ADC_WIDTH-1], hi_q};
  assign value_ext = {value[ADC_WIDTH-1], value};

  // keep HI until its LO partner arrives
  always_ff @(posedge clk)
  begin
    if (sample_valid && sample.phase == PHASE_HI)
      hi_q <= value;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      reading       <= '0;
      reading_count <= '0;
    end
    else if (sample_valid)
    begin
      // LO completes an autozero pair
      if (sample.phase == PHASE_LO)
      begin
        reading       <= hi_ext - value_ext;
        reading_count <= reading_count + 1'b1;
      end
      // HI alone is a reading without autozero
      else if (!cfg.az_mode)
      begin
        reading       <= value_ext;
        reading_count <= reading_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/adc_capture.sv
// expects at most one trigger per conversion and ADC_WIDTH no wider than SAMPLE_WIDTH
`timescale 1ns/1ns
`default_nettype none

module adc_capture #(
  parameter int ADC_WIDTH = 24
) (
  input  wire                            clk,
  input  wire                            reset,
  input  wire                            adc_trig,
  input  wire meas_sample_pkg::phase_t   trig_phase,
  input  wire                            adc_valid,
  input  wire logic signed [ADC_WIDTH-1:0] adc_data,
  output meas_sample_pkg::sample_t       sample,
  output logic                           sample_valid
);

  import meas_sample_pkg::*;

  phase_t phase_q;  // phase of the conversion in progress

  // tag and data registers
  always_ff @(posedge clk)
  begin
    if (adc_trig)
      phase_q <= trig_phase;
    if (adc_valid)
    begin
      sample.phase <= phase_q;
      // sign extend to the common sample width
      sample.value <= SAMPLE_WIDTH'(adc_data);
    end
  end

  // valid trails adc_valid by one clock
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      sample_valid <= 1'b0;
    else
      sample_valid <= adc_valid;
  end

endmodule

`default_nettype wire

//--- source/modulation_seq.sv
// trigger comes precharge_n+2 clocks after precharge entry and az_mode is taken once per cycle
`timescale 1ns/1ns
`default_nettype none

module modulation_seq #(
  parameter int COUNT_WIDTH = 24
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire meas_cfg_pkg::meas_cfg_t cfg,
  input  wire                          adc_valid,
  output logic                         adc_trig,
  output meas_sample_pkg::phase_t      trig_phase,
  output logic [3:0]                   azmux,
  output logic                         sw_pc_ctl,
  output logic                         led,
  output logic [1:0]                   monitor
);

  import meas_cfg_pkg::*;
  import meas_sample_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_PRECHARGE,
    ST_HI_TRIG,
    ST_HI_WAIT,
    ST_LO_MUX,
    ST_LO_SETTLE,
    ST_LO_TRIG,
    ST_LO_WAIT,
    ST_DONE
  } state_t;

  state_t                 state;
  logic [COUNT_WIDTH-1:0] count_down;  // clocks left in the current timed phase
  logic                   az_q;        // mode latched for the whole cycle

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state      <= ST_IDLE;
      count_down <= '0;
      az_q       <= 1'b0;
      adc_trig   <= 1'b0;
      trig_phase <= PHASE_HI;
      azmux      <= AZMUX_HI;
      sw_pc_ctl  <= SW_PC_BOOT;
      led        <= 1'b0;
      monitor    <= 2'b00;
    end
    else
    begin
      // free running countdown, reloaded on each timed phase
      count_down <= count_down - 1'b1;
      // trigger is a single clock pulse
      adc_trig   <= 1'b0;

      case (state)
        // run is only sampled here, so a stop lands at the end of a cycle
        ST_IDLE:
          if (cfg.run)
          begin
            state      <= ST_PRECHARGE;
            count_down <= COUNT_WIDTH'(cfg.precharge_n);
            az_q       <= cfg.az_mode;
            azmux      <= AZMUX_HI;   // switch is already in boot
            sw_pc_ctl  <= SW_PC_BOOT;
            monitor    <= 2'b01;
          end

        ////////////////////////////////////////////////////////////
        // HI conversion

        // precharge pause, signal protected by the boot position
        ST_PRECHARGE:
          if (count_down == '0)
          begin
            state     <= ST_HI_TRIG;
            sw_pc_ctl <= SW_PC_SIGNAL;
            monitor   <= 2'b10;
          end
        ST_HI_TRIG:
        begin
          state      <= ST_HI_WAIT;
          adc_trig   <= 1'b1;
          trig_phase <= PHASE_HI;
        end
        // slow ADC stalls here
        ST_HI_WAIT:
          if (adc_valid)
          begin
            sw_pc_ctl <= SW_PC_BOOT;
            state     <= az_q ? ST_LO_MUX : ST_DONE;
          end

        ////////////////////////////////////////////////////////////
        // LO conversion, autozero only

        // mux moves one clock after the switch went to boot
        ST_LO_MUX:
        begin
          state      <= ST_LO_SETTLE;
          azmux      <= AZMUX_LO;
          count_down <= COUNT_WIDTH'(cfg.settle_n);
          monitor    <= 2'b01;
        end
        ST_LO_SETTLE:
          if (count_down == '0)
          begin
            state   <= ST_LO_TRIG;
            monitor <= 2'b10;
          end
        ST_LO_TRIG:
        begin
          state      <= ST_LO_WAIT;
          adc_trig   <= 1'b1;
          trig_phase <= PHASE_LO;
        end
        ST_LO_WAIT:
          if (adc_valid)
            state <= ST_DONE;

        // cycle complete, blink the led
        ST_DONE:
        begin
          state   <= ST_IDLE;
          led     <= ~led;
          monitor <= 2'b00;
        end

        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/meas_apb_regs.sv
// APB slave without wait states, reading and count registers are read only and COUNT_WIDTH <= 24
`timescale 1ns/1ns
`default_nettype none

module meas_apb_regs #(
  parameter int ADC_WIDTH   = 24,
  parameter int COUNT_WIDTH = 24
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire  [4:0]                   paddr,
  input  wire  [31:0]                  pwdata,
  output logic [31:0]                  prdata,
  output logic                         pready,
  output logic                         pslverr,
  output meas_cfg_pkg::meas_cfg_t      cfg,
  input  wire logic signed [ADC_WIDTH:0] reading,
  input  wire  [31:0]                  reading_count
);

  import meas_cfg_pkg::*;

  logic addr_hit;
  logic wr_access;

  // no wait states
  assign pready = 1'b1;

  // write happens in the access phase
  assign wr_access = psel && penable && pwrite;

  ////////////////////////////////////////////////////////////
  // address decode

  always_comb
  begin
    case (paddr)
      REG_CTRL, REG_PRECHARGE, REG_SETTLE, REG_READING, REG_COUNT:
        addr_hit = 1'b1;
      default:
        addr_hit = 1'b0;
    endcase
  end

  // error only flagged during the access cycle
  assign pslverr = psel && penable && !addr_hit;

  ////////////////////////////////////////////////////////////
  // writable registers

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      cfg <= '0;
    end
    else if (wr_access)
    begin
      case (paddr)
        REG_CTRL:
        begin
          cfg.run     <= pwdata[0];
          cfg.az_mode <= pwdata[1];
        end
        // durations limited to what the sequencer can count
        REG_PRECHARGE:
          cfg.precharge_n <= DUR_WIDTH'(pwdata[COUNT_WIDTH-1:0]);
        REG_SETTLE:
          cfg.settle_n <= DUR_WIDTH'(pwdata[COUNT_WIDTH-1:0]);
        // reading and count ignore writes
        default:
          ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux, data valid in the access cycle

  always_comb
  begin
    case (paddr)
      REG_CTRL:
        prdata = {30'b0, cfg.az_mode, cfg.run};
      REG_PRECHARGE:
        prdata = 32'(cfg.precharge_n);
      REG_SETTLE:
        prdata = 32'(cfg.settle_n);
      // sign extend the reading to the bus width
      REG_READING:
        prdata = {{(31 - ADC_WIDTH){reading[ADC_WIDTH]}}, reading};
      REG_COUNT:
        prdata = reading_count;
      default:
        prdata = 32'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/meas_sample_pkg.sv
// sample values are carried at SAMPLE_WIDTH bits so ADC_WIDTH may not exceed 24
`default_nettype none

package meas_sample_pkg;

  ////////////////////////////////////////////////////////////
  // conversion phase tags

  // which azmux input a conversion was taken from
  typedef enum logic {
    PHASE_HI = 1'b0,
    PHASE_LO = 1'b1
  } phase_t;

  ////////////////////////////////////////////////////////////
  // tagged ADC sample

  // widest supported ADC, narrower data is sign extended
  localparam int SAMPLE_WIDTH = 24;

  typedef struct packed {
    phase_t                   phase;  // phase announced at trigger time
    logic signed [SAMPLE_WIDTH-1:0] value;  // ADC result, two's complement
  } sample_t;

endpackage

`default_nettype wire

//--- source/meas_cfg_pkg.sv
// durations are at most 24 bits and a register write keeps only the low COUNT_WIDTH bits
`default_nettype none

package meas_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // configuration seen by the sequencer and combiner

  // width of the duration fields in the config word
  localparam int DUR_WIDTH = 24;

  typedef struct packed {
    logic                 run;          // start cycles, stop at end of current one
    logic                 az_mode;      // 1 = HI minus LO, 0 = HI only
    logic [DUR_WIDTH-1:0] precharge_n;  // precharge pause in clocks
    logic [DUR_WIDTH-1:0] settle_n;     // LO settle in clocks, autozero only
  } meas_cfg_t;

  ////////////////////////////////////////////////////////////
  // APB register map, byte addresses of 32 bit words

  localparam logic [4:0] REG_CTRL      = 5'd0;
  localparam logic [4:0] REG_PRECHARGE = 5'd4;
  localparam logic [4:0] REG_SETTLE    = 5'd8;
  localparam logic [4:0] REG_READING   = 5'd12;
  localparam logic [4:0] REG_COUNT     = 5'd16;

  ////////////////////////////////////////////////////////////
  // analog switch codes

  // azmux codes, bit 3 is the enable and the low bits select the switch
  localparam logic [3:0] AZMUX_HI = 4'b1000;  // S1, signal input
  localparam logic [3:0] AZMUX_LO = 4'b1001;  // S2, lo reference

  // precharge switch positions
  // boot protects the signal from azmux charge injection
  localparam logic SW_PC_BOOT   = 1'b0;
  localparam logic SW_PC_SIGNAL = 1'b1;

endpackage

`default_nettype wire
